/* project.f */
+incdir+design
design/iomem_pkg.sv
design/delayed_ram.sv
design/periph_regs.sv
design/iomem_fabric.sv
design/iomem_subsystem.sv
test/tb_iomem_subsystem.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  -f project.f --top-module tb_iomem_subsystem \
  --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_tb 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  echo "Pass line not found in simulator output"
  exit 1
fi

/* test/tb_iomem_subsystem.sv */
`timescale 1ns/1ps
`include "iomem_settings.svh"

module tb_iomem_subsystem;

  import iomem_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  logic       clk;
  logic       resetn;
  iomem_req_t bus_req;
  iomem_rsp_t bus_rsp;
  logic       pwm0;
  logic       pwm1;
  logic       uart_tx;

  int unsigned seed_val;
  int          last_latency;  // Rising edges from drive to ready
  int unsigned ram_word [8];
  logic [31:0] ram_model [8];

  iomem_subsystem uut (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req_i (bus_req),
    .bus_rsp_o (bus_rsp),
    .pwm0_o    (pwm0),
    .pwm1_o    (pwm1),
    .uart_tx_o (uart_tx)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("[FAIL] %s: expected %08h, actual %08h",
                                  name, expected, actual));
    end
  endtask

  function automatic logic [31:0] ram_addr(input int unsigned word);
    return {`RAM_REGION, 26'(word), 2'b00};
  endfunction

  function automatic logic [31:0] reg_addr(input int unsigned index);
    return {`PERIPH_REGION, 23'h0, 3'(index), 2'b00};
  endfunction

  // Expected word after a strobed write
  function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic bus_access(input logic [31:0] addr, input logic [3:0] strb,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int lat;
    lat = 0;
    @(posedge clk);
    bus_req <= '{valid: 1'b1, wstrb: strb, addr: addr, wdata: wdata};
    forever begin
      @(posedge clk);
      lat++;
      @(negedge clk);
      if (bus_rsp.ready) break;
      if (lat >= TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("No ready for address %08h after %0d cycles",
                                    addr, lat));
      end
    end
    rdata        = bus_rsp.rdata;
    last_latency = lat;
    @(posedge clk);
    bus_req.valid <= 1'b0;  // Dropped in the cycle after ready
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] data);
    logic [31:0] unused_rdata;
    bus_access(addr, strb, data, unused_rdata);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 4'h0, 32'h0, data);
  endtask

  task automatic test_ram_data();
    logic [31:0] data;
    logic [3:0]  strb;
    int unsigned base;
    base = $urandom % `RAM_WORDS;
    for (int i = 0; i < 8; i++) begin
      ram_word[i]  = (base + i * 131) % `RAM_WORDS;
      ram_model[i] = $urandom;
      bus_write(ram_addr(ram_word[i]), 4'hf, ram_model[i]);
      if (i % 2 == 1) begin  // Partial update on every other word
        strb = 4'($urandom % 15 + 1);
        data = $urandom;
        bus_write(ram_addr(ram_word[i]), strb, data);
        ram_model[i] = apply_strobes(ram_model[i], data, strb);
      end
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(ram_addr(ram_word[i]), data);
      check($sformatf("ram word %0d", ram_word[i]), ram_model[i], data);
    end
    bus_read(ram_addr(ram_word[0] + `RAM_WORDS), data);  // Index above depth wraps
    check("ram index wrap", ram_model[0], data);
  endtask

  task automatic test_latency();
    logic [31:0] data;
    bus_read(ram_addr(ram_word[2]), data);
    check("ram read latency", `RAM_DELAY, last_latency);
    bus_write(ram_addr(ram_word[2]), 4'hf, ram_model[2]);
    check("ram write latency", `RAM_DELAY, last_latency);
    bus_read(reg_addr(6), data);
    check("reg read latency", 1, last_latency);
    check("uart divider after reset", `UART_DIV_RESET, data);
  endtask

  task automatic test_reg_readback();
    int          regs [5] = '{0, 1, 2, 3, 6};
    logic [31:0] model;
    logic [31:0] data;
    logic [3:0]  strb;
    for (int i = 0; i < 5; i++) begin
      model = $urandom;
      bus_write(reg_addr(regs[i]), 4'hf, model);
      strb = 4'($urandom % 15 + 1);
      data = $urandom;
      bus_write(reg_addr(regs[i]), strb, data);
      model = apply_strobes(model, data, strb);
      bus_read(reg_addr(regs[i]), data);
      check($sformatf("reg %0d readback", regs[i]), model, data);
    end
    bus_read(reg_addr(7), data);
    check("reg 7 reads zero", 0, data);
  endtask

  task automatic count_pwm_highs(input int cycles, output int high0, output int high1);
    high0 = 0;
    high1 = 0;
    repeat (cycles) begin
      @(negedge clk);
      if (pwm0) high0++;
      if (pwm1) high1++;
    end
  endtask

  task automatic test_pwm();
    logic [31:0] duty0;
    logic [31:0] duty1;
    int          high0;
    int          high1;
    duty0 = 1 + $urandom % 9;
    duty1 = 1 + $urandom % 6;
    bus_write(reg_addr(0), 4'hf, 32'd10);
    bus_write(reg_addr(1), 4'hf, duty0);
    bus_write(reg_addr(2), 4'hf, 32'd7);
    bus_write(reg_addr(3), 4'hf, duty1);
    count_pwm_highs(70, high0, high1);  // 7 periods of pwm0 and 10 of pwm1
    check("pwm0 high cycles", duty0 * 7, high0);
    check("pwm1 high cycles", duty1 * 10, high1);
    bus_write(reg_addr(3), 4'hf, 32'd0);
    count_pwm_highs(70, high0, high1);
    check("pwm0 high cycles again", duty0 * 7, high0);
    check("pwm1 zero duty", 0, high1);
  endtask

  task automatic test_uart();
    logic [7:0]  tx_byte;
    logic [7:0]  other_byte;
    logic [31:0] div;
    logic [9:0]  line;
    logic [31:0] data;
    int          waited;
    tx_byte    = 8'($urandom);
    other_byte = ~tx_byte;
    div        = 4 + 2 * ($urandom % 3);
    bus_write(reg_addr(6), 4'hf, div);
    fork
      begin
        waited = 0;
        do begin
          @(negedge clk);
          waited++;
          if (waited > TIMEOUT_CYCLES) stop_with_failure("UART start bit never appeared");
        end while (uart_tx);
        repeat (div / 2) @(negedge clk);  // Middle of the start bit
        line[0] = uart_tx;
        for (int b = 1; b < 10; b++) begin
          repeat (div) @(negedge clk);
          line[b] = uart_tx;
        end
      end
      begin
        bus_write(reg_addr(4), 4'h1, {24'h0, tx_byte});
        bus_read(reg_addr(5), data);
        check("uart busy during frame", 1, data);
        bus_write(reg_addr(4), 4'h1, {24'h0, other_byte});  // Lands while busy
        bus_read(reg_addr(4), data);
        check("uart last byte written", {24'h0, other_byte}, data);
      end
    join
    check("uart start bit", 0, 32'(line[0]));
    check("uart data bits", 32'(tx_byte), 32'(line[8:1]));
    check("uart stop bit", 1, 32'(line[9]));
    repeat (div) @(negedge clk);  // Past the end of the stop bit
    bus_read(reg_addr(5), data);
    check("uart busy after frame", 0, data);
    for (int c = 0; c < 12 * div; c++) begin
      @(negedge clk);
      check("uart line idle after frame", 1, 32'(uart_tx));
    end
  endtask

  task automatic test_unmapped();
    logic [31:0] addr;
    logic [31:0] data;
    bus_read(32'h1000_0010, data);
    check("unmapped read data", 0, data);
    check("unmapped read latency", 1, last_latency);
    addr = ram_addr(ram_word[3]);
    addr[31:28] = 4'h2;  // Same word bits as a RAM word
    bus_write(addr, 4'hf, ~ram_model[3]);
    check("unmapped write latency", 1, last_latency);
    addr = reg_addr(0);
    addr[31:28] = 4'hc;
    bus_write(addr, 4'hf, 32'hffff_ffff);
    bus_read(ram_addr(ram_word[3]), data);
    check("ram after unmapped write", ram_model[3], data);
    bus_read(reg_addr(0), data);
    check("pwm0 period after unmapped write", 10, data);
  endtask

  initial begin
    seed_val = $urandom(32'h3ac7_0f8c);
    resetn   = 1'b0;
    bus_req  = '0;
    repeat (3) @(posedge clk);
    resetn <= 1'b1;
    @(negedge clk);
    check("ready after reset", 0, 32'(bus_rsp.ready));
    check("uart line after reset", 1, 32'(uart_tx));
    check("pwm outputs after reset", 0, 32'({pwm1, pwm0}));
    test_ram_data();
    test_latency();
    test_reg_readback();
    test_pwm();
    test_uart();
    test_unmapped();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* design/iomem_subsystem.sv */
`timescale 1ns/1ps

module iomem_subsystem (
  input  logic                  clk,
  input  logic                  resetn,
  input  iomem_pkg::iomem_req_t bus_req_i,
  output iomem_pkg::iomem_rsp_t bus_rsp_o,
  output logic                  pwm0_o,
  output logic                  pwm1_o,
  output logic                  uart_tx_o
);

  import iomem_pkg::*;

  iomem_req_t ram_req;
  iomem_req_t reg_req;
  iomem_rsp_t ram_rsp;
  iomem_rsp_t reg_rsp;

  iomem_fabric u_fabric (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .ram_req_o (ram_req),
    .reg_req_o (reg_req),
    .ram_rsp_i (ram_rsp),
    .reg_rsp_i (reg_rsp)
  );

  delayed_ram u_ram (
    .clk    (clk),
    .resetn (resetn),
    .req_i  (ram_req),
    .rsp_o  (ram_rsp)
  );

  periph_regs u_regs (
    .clk       (clk),
    .resetn    (resetn),
    .req_i     (reg_req),
    .rsp_o     (reg_rsp),
    .pwm0_o    (pwm0_o),
    .pwm1_o    (pwm1_o),
    .uart_tx_o (uart_tx_o)
  );

endmodule

/* design/iomem_fabric.sv */
`timescale 1ns/1ps
`include "iomem_settings.svh"

module iomem_fabric (
  input  logic                  clk,
  input  logic                  resetn,
  input  iomem_pkg::iomem_req_t bus_req_i,
  output iomem_pkg::iomem_rsp_t bus_rsp_o,
  output iomem_pkg::iomem_req_t ram_req_o,
  output iomem_pkg::iomem_req_t reg_req_o,
  input  iomem_pkg::iomem_rsp_t ram_rsp_i,
  input  iomem_pkg::iomem_rsp_t reg_rsp_i
);

  import iomem_pkg::*;

  iomem_addr_u addr_u;
  logic        sel_ram;
  logic        sel_reg;
  logic        sel_none;
  logic        none_ready_q;

  assign addr_u   = bus_req_i.addr;
  assign sel_ram  = addr_u.mem.region == `RAM_REGION;
  assign sel_reg  = addr_u.mem.region == `PERIPH_REGION;
  assign sel_none = !sel_ram && !sel_reg;

  // Only the addressed part sees valid
  always_comb begin
    ram_req_o       = bus_req_i;
    ram_req_o.valid = bus_req_i.valid && sel_ram;
    reg_req_o       = bus_req_i;
    reg_req_o.valid = bus_req_i.valid && sel_reg;
  end

  // Unmapped accesses answer by themselves after one cycle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      none_ready_q <= 1'b0;
    end else begin
      none_ready_q <= bus_req_i.valid && sel_none && !none_ready_q;
    end
  end

  // Request is held until ready, so the region stays valid for the merge
  always_comb begin
    if (sel_ram) begin
      bus_rsp_o = ram_rsp_i;
    end else if (sel_reg) begin
      bus_rsp_o = reg_rsp_i;
    end else begin
      bus_rsp_o.ready = none_ready_q;
      bus_rsp_o.rdata = '0;
    end
  end

endmodule

/* design/periph_regs.sv */
`timescale 1ns/1ps
`include "iomem_settings.svh"

module periph_regs (
  input  logic                  clk,
  input  logic                  resetn,
  input  iomem_pkg::iomem_req_t req_i,
  output iomem_pkg::iomem_rsp_t rsp_o,
  output logic                  pwm0_o,
  output logic                  pwm1_o,
  output logic                  uart_tx_o
);

  import iomem_pkg::*;

  iomem_addr_u addr_u;
  logic [2:0]  idx;
  logic        accept;
  logic        wr_en;

  logic        ready_q;
  logic [31:0] rdata_d;
  logic [31:0] rdata_q;

  logic [31:0] pwm_period_q [2];
  logic [31:0] pwm_duty_q   [2];
  logic [31:0] pwm_cnt_q    [2];
  logic [1:0]  pwm_out;

  logic [31:0] uart_div_q;
  logic [7:0]  uart_last_q;
  logic [9:0]  frame_q;
  logic [3:0]  bit_cnt_q;
  logic [31:0] baud_cnt_q;
  logic        uart_busy_q;
  logic        uart_start;
  logic        bit_done;

  assign addr_u = req_i.addr;
  assign idx    = addr_u.regs.reg_index;
  assign accept = req_i.valid && !ready_q;  // Valid is still high in the ready cycle
  assign wr_en  = accept && (|req_i.wstrb);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  // PWM channel ch has its period at index 2*ch and its duty at 2*ch+1
  for (genvar ch = 0; ch < 2; ch++) begin : g_pwm
    always_ff @(posedge clk) begin
      if (!resetn) begin
        pwm_period_q[ch] <= '0;
        pwm_duty_q[ch]   <= '0;
        pwm_cnt_q[ch]    <= '0;
      end else begin
        if (wr_en && idx == 3'(2*ch)) begin
          pwm_period_q[ch] <= merge_bytes(pwm_period_q[ch], req_i.wdata, req_i.wstrb);
        end
        if (wr_en && idx == 3'(2*ch+1)) begin
          pwm_duty_q[ch] <= merge_bytes(pwm_duty_q[ch], req_i.wdata, req_i.wstrb);
        end
        if (pwm_cnt_q[ch] + 32'd1 >= pwm_period_q[ch]) begin
          pwm_cnt_q[ch] <= '0;  // Also holds at 0 for period 0
        end else begin
          pwm_cnt_q[ch] <= pwm_cnt_q[ch] + 32'd1;
        end
      end
    end

    assign pwm_out[ch] = pwm_cnt_q[ch] < pwm_duty_q[ch];
  end

  assign pwm0_o = pwm_out[0];
  assign pwm1_o = pwm_out[1];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      uart_div_q <= 32'(`UART_DIV_RESET);
    end else if (wr_en && idx == 3'd6) begin
      uart_div_q <= merge_bytes(uart_div_q, req_i.wdata, req_i.wstrb);
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en && idx == 3'd4 && req_i.wstrb[0]) begin
      uart_last_q <= req_i.wdata[7:0];
    end
  end

  // 8N1 transmitter shifting the frame out LSB first
  assign uart_start = wr_en && idx == 3'd4 && req_i.wstrb[0] && !uart_busy_q;
  assign bit_done   = baud_cnt_q + 32'd1 >= uart_div_q;  // Divider 0 acts as 1

  always_ff @(posedge clk) begin
    if (!resetn) begin
      frame_q     <= '1;  // Line idles high
      bit_cnt_q   <= '0;
      baud_cnt_q  <= '0;
      uart_busy_q <= 1'b0;
    end else if (uart_start) begin
      frame_q     <= {1'b1, req_i.wdata[7:0], 1'b0};
      bit_cnt_q   <= '0;
      baud_cnt_q  <= '0;
      uart_busy_q <= 1'b1;
    end else if (uart_busy_q) begin
      if (bit_done) begin
        baud_cnt_q <= '0;
        frame_q    <= {1'b1, frame_q[9:1]};
        if (bit_cnt_q == 4'd9) begin
          uart_busy_q <= 1'b0;  // Stop bit finished
        end else begin
          bit_cnt_q <= bit_cnt_q + 4'd1;
        end
      end else begin
        baud_cnt_q <= baud_cnt_q + 32'd1;
      end
    end
  end

  assign uart_tx_o = frame_q[0];

  always_comb begin
    case (idx)
      3'd0:    rdata_d = pwm_period_q[0];
      3'd1:    rdata_d = pwm_duty_q[0];
      3'd2:    rdata_d = pwm_period_q[1];
      3'd3:    rdata_d = pwm_duty_q[1];
      3'd4:    rdata_d = {24'h0, uart_last_q};
      3'd5:    rdata_d = {31'h0, uart_busy_q};
      3'd6:    rdata_d = uart_div_q;
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      rdata_q <= rdata_d;
    end
  end

  always_comb begin
    rsp_o.ready = ready_q;
    rsp_o.rdata = rdata_q;
  end

endmodule

/* design/delayed_ram.sv */
`timescale 1ns/1ps
`include "iomem_settings.svh"

module delayed_ram (
  input  logic                  clk,
  input  logic                  resetn,
  input  iomem_pkg::iomem_req_t req_i,
  output iomem_pkg::iomem_rsp_t rsp_o
);

  import iomem_pkg::*;

  localparam int ADDR_W = $clog2(`RAM_WORDS);

  iomem_addr_u       addr_u;
  logic [ADDR_W-1:0] word_idx;

  logic [`RAM_DELAY-1:0] delay_q;
  logic [31:0]           mem_q [`RAM_WORDS];
  logic [31:0]           rdata_q;

  logic launch_ready;
  logic ready;

  assign addr_u   = req_i.addr;
  assign word_idx = addr_u.mem.word_index[ADDR_W-1:0];  // Upper index bits wrap

  // Strobe launched on valid travels up to the top bit
  always_ff @(posedge clk) begin
    if (!resetn) begin
      delay_q <= '0;
    end else begin
      if (delay_q == '0) begin
        delay_q <= {{(`RAM_DELAY-1){1'b0}}, req_i.valid};  // Only loads while empty
      end else begin
        delay_q <= delay_q << 1;
      end
    end
  end

  assign launch_ready = delay_q[`RAM_DELAY-2];  // Ready rises on the next edge
  assign ready        = delay_q[`RAM_DELAY-1];

  // Read one edge ahead so rdata lines up with ready
  always_ff @(posedge clk) begin
    if (launch_ready) begin
      rdata_q <= mem_q[word_idx];
    end
  end

  // Write lands on the ready edge
  always_ff @(posedge clk) begin
    if (ready && req_i.valid && (|req_i.wstrb)) begin
      mem_q[word_idx] <= merge_bytes(mem_q[word_idx], req_i.wdata, req_i.wstrb);
    end
  end

  always_comb begin
    rsp_o.ready = ready;
    rsp_o.rdata = rdata_q;
  end

endmodule

/* design/iomem_pkg.sv */
package iomem_pkg;

  typedef struct packed {
    logic        valid;
    logic [3:0]  wstrb;   // Any bit set means write
    logic [31:0] addr;
    logic [31:0] wdata;
  } iomem_req_t;

  typedef struct packed {
    logic        ready;   // One cycle pulse
    logic [31:0] rdata;   // Valid with ready
  } iomem_rsp_t;

  typedef struct packed {
    logic [3:0]  region;
    logic [25:0] word_index;
    logic [1:0]  byte_offset;
  } mem_view_t;

  typedef struct packed {
    logic [3:0]  region;
    logic [22:0] unused;
    logic [2:0]  reg_index;
    logic [1:0]  byte_offset;
  } reg_view_t;

  typedef union packed {
    mem_view_t mem;
    reg_view_t regs;
  } iomem_addr_u;

  // Byte lane merge under write strobes
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  strb);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

endpackage

/* design/iomem_settings.svh */
`ifndef IOMEM_SETTINGS_SVH
`define IOMEM_SETTINGS_SVH

// Address map regions selected by addr[31:28]
`define RAM_REGION      4'h4
`define PERIPH_REGION   4'h8

// RAM geometry and response delay
`define RAM_WORDS       1024     // Power of two so upper word bits wrap
`define RAM_DELAY       16       // Cycles from valid to ready

// UART bit time in clk cycles after reset
`define UART_DIV_RESET  16

`endif
